// File: verilog/procyon_pkg.sv
// shared widths, types, opcodes and stage structs for the integer execution unit, compiled first
package procyon_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 32;
    localparam int TAG_WIDTH   = 6;                 // sized for a 64 entry reorder buffer
    localparam int SHAMT_WIDTH = 5;

    typedef logic        [DATA_WIDTH-1:0]  procyon_data_t;
    typedef logic signed [DATA_WIDTH-1:0]  procyon_signed_data_t;
    typedef logic        [ADDR_WIDTH-1:0]  procyon_addr_t;
    typedef logic        [TAG_WIDTH-1:0]   procyon_tag_t;
    typedef logic        [SHAMT_WIDTH-1:0] procyon_shamt_t;
    typedef logic        [6:0]             procyon_opcode_t;
    typedef logic        [2:0]             procyon_funct3_t;
    typedef logic        [6:0]             procyon_funct7_t;

    typedef enum logic [3:0] {
        ALU_FUNC_ADD = 4'b0000,
        ALU_FUNC_SUB = 4'b0001,
        ALU_FUNC_AND = 4'b0010,
        ALU_FUNC_OR  = 4'b0011,
        ALU_FUNC_XOR = 4'b0100,
        ALU_FUNC_SLL = 4'b0101,
        ALU_FUNC_SRL = 4'b0110,
        ALU_FUNC_SRA = 4'b0111,
        ALU_FUNC_EQ  = 4'b1000,                     // compare functions return 0 or 1
        ALU_FUNC_NE  = 4'b1001,
        ALU_FUNC_LT  = 4'b1010,
        ALU_FUNC_LTU = 4'b1011,
        ALU_FUNC_GE  = 4'b1100,
        ALU_FUNC_GEU = 4'b1101
    } procyon_alu_func_t;

    localparam procyon_opcode_t OPC_OP     = 7'b0110011;
    localparam procyon_opcode_t OPC_OPIMM  = 7'b0010011;
    localparam procyon_opcode_t OPC_LUI    = 7'b0110111;
    localparam procyon_opcode_t OPC_AUIPC  = 7'b0010111;
    localparam procyon_opcode_t OPC_JAL    = 7'b1101111;
    localparam procyon_opcode_t OPC_JALR   = 7'b1100111;
    localparam procyon_opcode_t OPC_BRANCH = 7'b1100011;

    // one issued operation as it leaves the reservation station
    typedef struct packed {
        procyon_opcode_t opcode;
        procyon_funct3_t funct3;
        procyon_funct7_t funct7;
        procyon_data_t   src_a;
        procyon_data_t   src_b;
        procyon_data_t   imm;                       // already sign extended
        procyon_addr_t   iaddr;
        procyon_tag_t    tag;
    } ieu_issue_t;

    typedef struct packed {
        procyon_alu_func_t alu_func;
        procyon_data_t     src_a;
        procyon_data_t     src_b;
        procyon_addr_t     iaddr;
        procyon_data_t     imm_b;                   // branch offset
        procyon_shamt_t    shamt;
        procyon_tag_t      tag;
        logic              jmp;
        logic              br;
    } ieu_dec_t;

    typedef struct packed {
        procyon_data_t data;
        procyon_addr_t addr;
        procyon_tag_t  tag;
        logic          redirect;                    // fetch must restart at addr
    } ieu_result_t;

endpackage

// File: verilog/ieu_id.sv
// decode stage of the integer execution unit, turns an issued operation into ALU controls
`timescale 1ns/10ps

module ieu_id (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  procyon_pkg::ieu_issue_t i_issue,
    input  logic                    i_valid,

    output procyon_pkg::ieu_dec_t   o_dec,
    output logic                    o_valid
);

    procyon_pkg::ieu_dec_t          dec;
    procyon_pkg::procyon_alu_func_t op_func;
    procyon_pkg::procyon_alu_func_t br_func;
    logic                           alt;            // funct7 bit 5 picks SUB and SRA
    logic                           is_op;

    assign alt   = i_issue.funct7[5];
    assign is_op = (i_issue.opcode == procyon_pkg::OPC_OP);

    // shared by register and immediate ALU operations
    always_comb begin
        case (i_issue.funct3)
            3'b000:  op_func = (alt && is_op) ? procyon_pkg::ALU_FUNC_SUB
                                              : procyon_pkg::ALU_FUNC_ADD;
            3'b001:  op_func = procyon_pkg::ALU_FUNC_SLL;
            3'b010:  op_func = procyon_pkg::ALU_FUNC_LT;   // SLT
            3'b011:  op_func = procyon_pkg::ALU_FUNC_LTU;  // SLTU
            3'b100:  op_func = procyon_pkg::ALU_FUNC_XOR;
            3'b101:  op_func = alt ? procyon_pkg::ALU_FUNC_SRA : procyon_pkg::ALU_FUNC_SRL;
            3'b110:  op_func = procyon_pkg::ALU_FUNC_OR;
            default: op_func = procyon_pkg::ALU_FUNC_AND;
        endcase
    end

    always_comb begin
        case (i_issue.funct3)
            3'b000:  br_func = procyon_pkg::ALU_FUNC_EQ;
            3'b001:  br_func = procyon_pkg::ALU_FUNC_NE;
            3'b100:  br_func = procyon_pkg::ALU_FUNC_LT;
            3'b101:  br_func = procyon_pkg::ALU_FUNC_GE;
            3'b110:  br_func = procyon_pkg::ALU_FUNC_LTU;
            3'b111:  br_func = procyon_pkg::ALU_FUNC_GEU;
            default: br_func = procyon_pkg::ALU_FUNC_EQ;   // 010 and 011 are not branches
        endcase
    end

    // anything not listed falls through as an add of two zeros
    always_comb begin
        dec.alu_func = procyon_pkg::ALU_FUNC_ADD;
        dec.src_a    = '0;
        dec.src_b    = '0;
        dec.iaddr    = i_issue.iaddr;
        dec.imm_b    = i_issue.imm;
        dec.shamt    = i_issue.src_b[procyon_pkg::SHAMT_WIDTH-1:0];
        dec.tag      = i_issue.tag;
        dec.jmp      = 1'b0;
        dec.br       = 1'b0;

        case (i_issue.opcode)
            procyon_pkg::OPC_OP: begin
                dec.alu_func = op_func;
                dec.src_a    = i_issue.src_a;
                dec.src_b    = i_issue.src_b;
            end
            procyon_pkg::OPC_OPIMM: begin
                dec.alu_func = op_func;
                dec.src_a    = i_issue.src_a;
                dec.src_b    = i_issue.imm;
                dec.shamt    = i_issue.imm[procyon_pkg::SHAMT_WIDTH-1:0];
            end
            procyon_pkg::OPC_LUI: begin
                dec.src_b    = i_issue.imm;
            end
            procyon_pkg::OPC_AUIPC: begin
                dec.src_a    = i_issue.iaddr;
                dec.src_b    = i_issue.imm;
            end
            procyon_pkg::OPC_JAL: begin
                dec.src_a    = i_issue.iaddr;
                dec.src_b    = i_issue.imm;
                dec.jmp      = 1'b1;
            end
            procyon_pkg::OPC_JALR: begin
                dec.src_a    = i_issue.src_a;
                dec.src_b    = i_issue.imm;
                dec.jmp      = 1'b1;
            end
            procyon_pkg::OPC_BRANCH: begin
                dec.alu_func = br_func;             // imm stays in imm_b as the offset
                dec.src_a    = i_issue.src_a;
                dec.src_b    = i_issue.src_b;
                dec.br       = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        o_dec <= dec;
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

// File: verilog/ieu_ex.sv
// execute stage of the integer execution unit, runs the ALU and resolves jumps and branches
`timescale 1ns/10ps

module ieu_ex (
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  procyon_pkg::ieu_dec_t    i_dec,
    input  logic                     i_valid,

    output procyon_pkg::ieu_result_t o_result,
    output logic                     o_valid
);

    procyon_pkg::procyon_data_t             result;
    logic [2*procyon_pkg::DATA_WIDTH-1:0]   e_src_a;    // sign extended copy for SRA
    logic [2*procyon_pkg::DATA_WIDTH-1:0]   sra_full;
    procyon_pkg::procyon_signed_data_t      s_src_a;
    procyon_pkg::procyon_signed_data_t      s_src_b;
    logic                                   cmp;
    procyon_pkg::ieu_result_t               result_next;

    assign e_src_a  = {{procyon_pkg::DATA_WIDTH{i_dec.src_a[procyon_pkg::DATA_WIDTH-1]}},
                       i_dec.src_a};
    assign sra_full = e_src_a >> i_dec.shamt;
    assign s_src_a  = i_dec.src_a;
    assign s_src_b  = i_dec.src_b;

    always_comb begin
        case (i_dec.alu_func)
            procyon_pkg::ALU_FUNC_EQ:  cmp = (i_dec.src_a == i_dec.src_b);
            procyon_pkg::ALU_FUNC_NE:  cmp = (i_dec.src_a != i_dec.src_b);
            procyon_pkg::ALU_FUNC_LT:  cmp = (s_src_a < s_src_b);
            procyon_pkg::ALU_FUNC_LTU: cmp = (i_dec.src_a < i_dec.src_b);
            procyon_pkg::ALU_FUNC_GE:  cmp = (s_src_a >= s_src_b);
            procyon_pkg::ALU_FUNC_GEU: cmp = (i_dec.src_a >= i_dec.src_b);
            default:                   cmp = 1'b0;
        endcase
    end

    always_comb begin
        case (i_dec.alu_func)
            procyon_pkg::ALU_FUNC_ADD: result = i_dec.src_a + i_dec.src_b;
            procyon_pkg::ALU_FUNC_SUB: result = i_dec.src_a - i_dec.src_b;
            procyon_pkg::ALU_FUNC_AND: result = i_dec.src_a & i_dec.src_b;
            procyon_pkg::ALU_FUNC_OR:  result = i_dec.src_a | i_dec.src_b;
            procyon_pkg::ALU_FUNC_XOR: result = i_dec.src_a ^ i_dec.src_b;
            procyon_pkg::ALU_FUNC_SLL: result = i_dec.src_a << i_dec.shamt;
            procyon_pkg::ALU_FUNC_SRL: result = i_dec.src_a >> i_dec.shamt;
            procyon_pkg::ALU_FUNC_SRA: result = sra_full[procyon_pkg::DATA_WIDTH-1:0];
            default:                   result = {{(procyon_pkg::DATA_WIDTH-1){1'b0}}, cmp};
        endcase
    end

    always_comb begin
        result_next.tag = i_dec.tag;
        if (i_dec.jmp) begin
            result_next.data     = i_dec.iaddr + procyon_pkg::procyon_addr_t'(4);  // link address
            result_next.addr     = {result[procyon_pkg::DATA_WIDTH-1:1], 1'b0};
            result_next.redirect = i_valid;
        end else if (i_dec.br) begin
            result_next.data     = result;
            result_next.addr     = i_dec.iaddr + i_dec.imm_b;
            result_next.redirect = i_valid & cmp;   // taken branch
        end else begin
            result_next.data     = result;
            result_next.addr     = '0;
            result_next.redirect = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        o_result.data <= result_next.data;
        o_result.addr <= result_next.addr;
        o_result.tag  <= result_next.tag;
        if (!i_rst_n) begin
            o_result.redirect <= 1'b0;
            o_valid           <= 1'b0;
        end else begin
            o_result.redirect <= result_next.redirect;
            o_valid           <= i_valid;
        end
    end

endmodule

// File: verilog/ieu.sv
// integer execution unit top, two stage pipeline of decode then execute
`timescale 1ns/10ps

module ieu (
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  procyon_pkg::ieu_issue_t  i_issue,
    input  logic                     i_valid,

    output procyon_pkg::ieu_result_t o_result,
    output logic                     o_valid
);

    procyon_pkg::ieu_dec_t dec;
    logic                  dec_valid;           // one decoded operation per cycle when high

    ieu_id ieu_id_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_issue   (i_issue),
        .i_valid   (i_valid),
        .o_dec     (dec),
        .o_valid   (dec_valid)
    );

    ieu_ex ieu_ex_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_dec     (dec),
        .i_valid   (dec_valid),
        .o_result  (o_result),
        .o_valid   (o_valid)
    );

endmodule

// File: tb/tb_ieu.sv
// self-checking testbench for the integer execution unit, reads tb/ieu_cases.txt from the project root
`timescale 1ns/10ps

module tb_ieu;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_SKEW = 1;                  // inputs change this long after the rising edge
    localparam int MAX_CASES  = 64;

    logic                     clk;
    logic                     i_rst_n;
    procyon_pkg::ieu_issue_t  i_issue;
    logic                     i_valid;
    procyon_pkg::ieu_result_t o_result;
    logic                     o_valid;

    procyon_pkg::ieu_issue_t  case_issue [MAX_CASES];
    procyon_pkg::ieu_result_t case_exp [MAX_CASES];
    procyon_pkg::ieu_result_t exp_q [$];            // oldest outstanding operation at the front
    int                       num_cases;
    int                       errors;
    logic                     cases_loaded;
    logic                     mon_en;
    logic [1:0]               valid_pipe;           // i_valid as sampled at the last two edges
    logic [31:0]              lfsr;

    ieu dut0 (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_issue  (i_issue),
        .i_valid  (i_valid),
        .o_result (o_result),
        .o_valid  (o_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
            errors++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] opc, f3, f7, a, b, imm, ia, tg, ed, ea, er;
        fd = $fopen("tb/ieu_cases.txt", "r");
        if (fd == 0) begin
            $display("error: the case file tb/ieu_cases.txt could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                            opc, f3, f7, a, b, imm, ia, tg, ed, ea, er);
                if (n == 11 && num_cases < MAX_CASES) begin
                    case_issue[num_cases].opcode = opc[6:0];
                    case_issue[num_cases].funct3 = f3[2:0];
                    case_issue[num_cases].funct7 = f7[6:0];
                    case_issue[num_cases].src_a  = a;
                    case_issue[num_cases].src_b  = b;
                    case_issue[num_cases].imm    = imm;
                    case_issue[num_cases].iaddr  = ia;
                    case_issue[num_cases].tag    = tg[5:0];
                    case_exp[num_cases].data     = ed;
                    case_exp[num_cases].addr     = ea;
                    case_exp[num_cases].tag      = tg[5:0];
                    case_exp[num_cases].redirect = er[0];
                    num_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    // outputs are looked at on the falling edge, half a period away from any change
    always @(negedge clk) begin
        procyon_pkg::ieu_result_t exp_res;
        if (mon_en) begin
            check_value("o_valid", o_valid, valid_pipe[1]);
            if (o_valid) begin
                if (exp_q.size() == 0) begin
                    $display("error: a valid result came out with no operation outstanding");
                    errors++;
                end else begin
                    exp_res = exp_q.pop_front();
                    check_value("o_result.data", o_result.data, exp_res.data);
                    check_value("o_result.addr", o_result.addr, exp_res.addr);
                    check_value("o_result.tag", o_result.tag, exp_res.tag);
                    check_value("o_result.redirect", o_result.redirect, exp_res.redirect);
                end
            end else begin
                check_value("o_result.redirect", o_result.redirect, 32'h0);
            end
        end
        valid_pipe = {valid_pipe[0], i_valid};
    end

    initial begin
        wait (cases_loaded);
        repeat (num_cases * 2 + 20) @(posedge clk);
        $display("error: timeout, the run did not finish within %0d clock periods",
                 num_cases * 2 + 20);
        $display("Test failed");
        $finish;
    end

    initial begin
        int idx;
        clk          = 1'b0;
        i_rst_n      = 1'b0;
        i_valid      = 1'b0;
        i_issue      = '0;
        errors       = 0;
        num_cases    = 0;
        cases_loaded = 1'b0;
        mon_en       = 1'b0;
        valid_pipe   = '0;
        lfsr         = 32'h55ccc896;

        load_cases();
        if (num_cases == 0) begin
            $display("error: no test cases were read from tb/ieu_cases.txt");
            errors++;
        end
        cases_loaded = 1'b1;

        @(posedge clk);
        mon_en = 1'b1;                              // valid bits are reset from here on
        repeat (2) @(posedge clk);
        #DRIVE_SKEW;
        i_rst_n = 1'b1;

        for (idx = 0; idx < num_cases; idx++) begin
            lfsr = lfsr_next(lfsr);
            if (lfsr[0]) begin                      // one idle cycle before this case
                i_valid = 1'b0;
                @(posedge clk);
                #DRIVE_SKEW;
            end
            i_issue = case_issue[idx];
            i_valid = 1'b1;
            exp_q.push_back(case_exp[idx]);
            @(posedge clk);
            #DRIVE_SKEW;
        end
        i_valid = 1'b0;
        i_issue = '0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("errors: %0d, cases run: %0d", errors, num_cases);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: procyon_ieu.f
verilog/procyon_pkg.sv
verilog/ieu_id.sv
verilog/ieu_ex.sv
verilog/ieu.sv
tb/tb_ieu.sv

// File: Bender.yml
package:
  name: procyon_ieu

sources:
  - files:
      - verilog/procyon_pkg.sv
      - verilog/ieu_id.sv
      - verilog/ieu_ex.sv
      - verilog/ieu.sv
  - target: test
    files:
      - tb/tb_ieu.sv

// File: tb/ieu_cases.txt
# opcode funct3 funct7 src_a src_b imm iaddr tag | expected data addr redirect
# all fields hex, one issued operation per line
33 0 00 00000005 00000007 00000000 00001000 01 0000000c 00000000 0
33 0 20 00000005 00000007 00000000 00001000 02 fffffffe 00000000 0
33 7 00 f0f0ff00 0ff0f0f0 00000000 00001000 03 00f0f000 00000000 0
33 6 00 f0f00000 0000000f 00000000 00001000 04 f0f0000f 00000000 0
33 4 00 ffff0000 0ff00ff0 00000000 00001000 05 f00f0ff0 00000000 0
33 1 00 00000003 00000024 00000000 00001000 06 00000030 00000000 0
33 5 00 80000000 0000001f 00000000 00001000 07 00000001 00000000 0
33 5 20 80000010 00000004 00000000 00001000 08 f8000001 00000000 0
33 2 00 ffffffff 00000001 00000000 00001000 09 00000001 00000000 0
33 3 00 ffffffff 00000001 00000000 00001000 0a 00000000 00000000 0
13 0 00 00000010 00000000 fffffffd 00001000 0b 0000000d 00000000 0
13 2 00 fffffff0 00000000 00000005 00001000 0c 00000001 00000000 0
13 3 00 00000005 00000000 fffffff0 00001000 0d 00000001 00000000 0
13 4 00 12345678 00000000 ffffffff 00001000 0e edcba987 00000000 0
13 6 00 00000100 00000000 00000055 00001000 0f 00000155 00000000 0
13 7 00 12345678 00000000 000000ff 00001000 10 00000078 00000000 0
13 1 00 00000001 00000000 0000001f 00001000 11 80000000 00000000 0
13 5 00 f0000000 00000000 00000008 00001000 12 00f00000 00000000 0
13 5 20 f0000000 00000000 00000408 00001000 13 fff00000 00000000 0
37 0 00 deadbeef 00000000 12345000 00001000 14 12345000 00000000 0
17 0 00 00000000 00000000 00002000 00001004 15 00003004 00000000 0
6f 0 00 00000000 00000000 00000100 00001008 16 0000100c 00001108 1
67 0 00 00002003 00000000 00000004 0000100c 17 00001010 00002006 1
63 0 00 00000005 00000005 00000020 00001010 18 00000001 00001030 1
63 0 00 00000005 00000006 00000020 00001014 19 00000000 00001034 0
63 1 00 00000005 00000006 fffffff0 00001018 1a 00000001 00001008 1
63 4 00 fffffffe 00000001 00000008 0000101c 1b 00000001 00001024 1
63 4 00 00000001 fffffffe 00000008 00001020 1c 00000000 00001028 0
63 5 00 00000001 fffffffe 00000010 00001024 1d 00000001 00001034 1
63 5 00 fffffffe 00000001 00000010 00001028 1e 00000000 00001038 0
63 6 00 00000001 fffffffe 00000040 0000102c 1f 00000001 0000106c 1
63 6 00 fffffffe 00000001 00000040 00001030 20 00000000 00001070 0
63 7 00 fffffffe 00000001 ffffff00 00001034 21 00000001 00000f34 1
63 7 00 00000001 fffffffe ffffff00 00001038 22 00000000 00000f38 0
03 2 00 00000044 00000055 00000010 0000103c 23 00000000 00000000 0
